// ==== activity_led.sv ====
/*
 * Stretches short activity strobes into an LED pulse long enough to see.
 * Any new activity restarts the hold time.
 */
`timescale 1ns/1ps

module activity_led import status_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic sys_reset,
    input  logic activity,
    output logic led
);

    logic [HOLD_CNT_WIDTH-1:0] hold_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_cnt <= '0;
        end else if (sys_reset) begin
            hold_cnt <= '0;
        end else if (activity) begin
            hold_cnt <= HOLD_CNT_WIDTH'(LED_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Lit for as long as the hold runs
    assign led = (hold_cnt != '0);

endmodule

// ==== board_pkg.sv ====
/*
 * Board input constants shared by the stabilizer and the reset generator.
 * Import with a wildcard in the module header.
 */
package board_pkg;

    // Stabilizer shape
    localparam int NUM_SYNC_INPUTS = 8;
    localparam int SYNC_STAGES     = 2;

    // Serial DTR reset pulse
    localparam int DTR_PULSE_CYCLES = 16;
    localparam int DTR_CNT_WIDTH    = $clog2(DTR_PULSE_CYCLES + 1);

    // Bit positions of the board inputs in the raw vector
    localparam int IDX_NRESET      = 0;
    localparam int IDX_DTR         = 1;
    localparam int IDX_USB0_NINT   = 2;
    localparam int IDX_USB1_NINT   = 3;
    localparam int IDX_ETH_INT     = 4;
    localparam int IDX_GP          = 5;
    localparam int IDX_FRAME_DRAWN = 6;
    localparam int IDX_BOOT_MODE   = 7;

endpackage

// ==== build.f ====
board_pkg.sv
status_pkg.sv
stable_if.sv
input_stabilizer.sv
reset_gen.sv
activity_led.sv
status_leds.sv
fpgc_board_ctrl.sv
tb_fpgc_board_ctrl.sv

// ==== fpgc_board_ctrl.sv ====
/*
 * System-control slice of the FPGC6 top level: input stabilizing,
 * reset generation and status LEDs, all on plain board pins.
 */
`timescale 1ns/1ps

module fpgc_board_ctrl import board_pkg::*, status_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,

    // Asynchronous board inputs
    input  logic                nreset,
    input  logic                uart0_dtr,
    input  logic                spi1_nint,
    input  logic                spi2_nint,
    input  logic                spi3_int,
    input  logic                spi4_gp,
    input  logic                frame_drawn,
    input  logic                boot_dip,

    // From CPU, memory unit and VRAM ports
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                qspi_mode,
    input  logic [3:0]          spi_cs_n,
    input  logic                ps2_int,
    input  logic [3:0]          vram_we,

    // Resets
    output logic                sys_reset,
    output logic                spi1_rst,
    output logic                spi2_rst,
    output logic                spi3_nrst,

    // Stabilized inputs for the rest of the system
    output logic                usb0_nint_stable,
    output logic                usb1_nint_stable,
    output logic                eth_int_stable,
    output logic                gp_stable,
    output logic                frame_drawn_stable,
    output logic                boot_mode,

    // Status LEDs
    output logic                led_booted,
    output logic                led_qspi,
    output logic                led_serial,
    output logic                led_flash,
    output logic                led_usb0,
    output logic                led_usb1,
    output logic                led_eth,
    output logic                led_ps2,
    output logic                led_gpu
);

    logic [NUM_SYNC_INPUTS-1:0] raw;

    stable_if stab_bus ();

    assign raw[IDX_NRESET]      = nreset;
    assign raw[IDX_DTR]         = uart0_dtr;
    assign raw[IDX_USB0_NINT]   = spi1_nint;
    assign raw[IDX_USB1_NINT]   = spi2_nint;
    assign raw[IDX_ETH_INT]     = spi3_int;
    assign raw[IDX_GP]          = spi4_gp;
    assign raw[IDX_FRAME_DRAWN] = frame_drawn;
    assign raw[IDX_BOOT_MODE]   = boot_dip;

    input_stabilizer u_stab (
        .clk    (clk),
        .arst_n (arst_n),
        .raw    (raw),
        .stab   (stab_bus.src)
    );

    reset_gen u_rst (
        .clk       (clk),
        .arst_n    (arst_n),
        .stab      (stab_bus.rst_sink),
        .sys_reset (sys_reset),
        .usb0_rst  (spi1_rst),
        .usb1_rst  (spi2_rst),
        .eth_nrst  (spi3_nrst)
    );

    status_leds u_leds (
        .clk        (clk),
        .arst_n     (arst_n),
        .sys_reset  (sys_reset),
        .stab       (stab_bus.led_sink),
        .pc         (pc),
        .qspi_mode  (qspi_mode),
        .spi_cs_n   (spi_cs_n),
        .ps2_int    (ps2_int),
        .vram_we    (vram_we),
        .led_booted (led_booted),
        .led_qspi   (led_qspi),
        .led_serial (led_serial),
        .led_flash  (led_flash),
        .led_usb0   (led_usb0),
        .led_usb1   (led_usb1),
        .led_eth    (led_eth),
        .led_ps2    (led_ps2),
        .led_gpu    (led_gpu)
    );

    // Interrupts and boot mode go straight out
    assign usb0_nint_stable   = stab_bus.usb0_nint_s;
    assign usb1_nint_stable   = stab_bus.usb1_nint_s;
    assign eth_int_stable     = stab_bus.eth_int_s;
    assign gp_stable          = stab_bus.gp_s;
    assign frame_drawn_stable = stab_bus.frame_drawn_s;
    assign boot_mode          = stab_bus.boot_mode_s;

endmodule

// ==== input_stabilizer.sv ====
/*
 * Flop chain for every asynchronous board input.
 * The last stage drives the named signals of stable_if.
 */
`timescale 1ns/1ps

module input_stabilizer import board_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [NUM_SYNC_INPUTS-1:0] raw,
    stable_if.src                      stab
);

    // Stage 0 samples the pins, stage SYNC_STAGES-1 is safe to use
    logic [SYNC_STAGES-1:0][NUM_SYNC_INPUTS-1:0] sync_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], raw};
        end
    end

    // Unpack onto the interface
    assign stab.nreset_s      = sync_q[SYNC_STAGES-1][IDX_NRESET];
    assign stab.dtr_s         = sync_q[SYNC_STAGES-1][IDX_DTR];
    assign stab.usb0_nint_s   = sync_q[SYNC_STAGES-1][IDX_USB0_NINT];
    assign stab.usb1_nint_s   = sync_q[SYNC_STAGES-1][IDX_USB1_NINT];
    assign stab.eth_int_s     = sync_q[SYNC_STAGES-1][IDX_ETH_INT];
    assign stab.gp_s          = sync_q[SYNC_STAGES-1][IDX_GP];
    assign stab.frame_drawn_s = sync_q[SYNC_STAGES-1][IDX_FRAME_DRAWN];
    assign stab.boot_mode_s   = sync_q[SYNC_STAGES-1][IDX_BOOT_MODE];

endmodule

// ==== reset_gen.sv ====
/*
 * System reset from the reset button and from a rising serial DTR.
 * Also drives the CH376 and W5500 reset pins in their own polarity.
 */
`timescale 1ns/1ps

module reset_gen import board_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    stable_if.rst_sink stab,
    output logic       sys_reset,
    output logic       usb0_rst,
    output logic       usb1_rst,
    output logic       eth_nrst
);

    logic                     dtr_q;
    logic                     dtr_rise;
    logic [DTR_CNT_WIDTH-1:0] pulse_cnt;
    logic                     dtr_pulse;

    // Opening the serial port raises DTR
    assign dtr_rise  = stab.dtr_s & ~dtr_q;
    assign dtr_pulse = (pulse_cnt != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dtr_q <= 1'b0;
        end else begin
            dtr_q <= stab.dtr_s;
        end
    end

    // Retriggerable pulse counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pulse_cnt <= '0;
        end else if (dtr_rise) begin
            pulse_cnt <= DTR_CNT_WIDTH'(DTR_PULSE_CYCLES);
        end else if (dtr_pulse) begin
            pulse_cnt <= pulse_cnt - 1'b1;
        end
    end

    // Board comes up in reset until the button input is seen released
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sys_reset <= 1'b1;
        end else begin
            sys_reset <= ~stab.nreset_s | dtr_pulse;
        end
    end

    // CH376 resets are active high, W5500 active low
    assign usb0_rst = sys_reset;
    assign usb1_rst = sys_reset;
    assign eth_nrst = ~sys_reset;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the fpgc_board_ctrl testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_fpgc_board_ctrl -f build.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

// ==== stable_if.sv ====
/*
 * Stabilized board inputs, driven by the stabilizer and read by the reset,
 * LED and top-level logic.
 */
`timescale 1ns/1ps

interface stable_if;

    logic nreset_s;
    logic dtr_s;
    logic usb0_nint_s;
    logic usb1_nint_s;
    logic eth_int_s;
    logic gp_s;
    logic frame_drawn_s;
    logic boot_mode_s;

    modport src (
        output nreset_s, dtr_s, usb0_nint_s, usb1_nint_s,
               eth_int_s, gp_s, frame_drawn_s, boot_mode_s
    );

    modport rst_sink (input nreset_s, dtr_s);

    modport led_sink (input dtr_s);

    modport mon (
        input usb0_nint_s, usb1_nint_s, eth_int_s, gp_s, frame_drawn_s, boot_mode_s
    );

endinterface

// ==== status_leds.sv ====
/*
 * Front panel status LEDs: six activity stretchers plus the booted,
 * QSPI and serial-open level indicators.
 */
`timescale 1ns/1ps

module status_leds import status_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                sys_reset,
    stable_if.led_sink          stab,
    input  logic [PC_WIDTH-1:0] pc,
    input  logic                qspi_mode,
    input  logic [3:0]          spi_cs_n,
    input  logic                ps2_int,
    input  logic [3:0]          vram_we,
    output logic                led_booted,
    output logic                led_qspi,
    output logic                led_serial,
    output logic                led_flash,
    output logic                led_usb0,
    output logic                led_usb1,
    output logic                led_eth,
    output logic                led_ps2,
    output logic                led_gpu
);

    logic [NUM_ACT_LEDS-1:0] act;
    logic [NUM_ACT_LEDS-1:0] act_led;

    // Chip selects are active low, so a selected device counts as activity
    assign act[ACT_FLASH] = ~spi_cs_n[0];
    assign act[ACT_USB0]  = ~spi_cs_n[1];
    assign act[ACT_USB1]  = ~spi_cs_n[2];
    assign act[ACT_ETH]   = ~spi_cs_n[3];
    assign act[ACT_PS2]   = ps2_int;

    // Any CPU write into one of the VRAMs
    assign act[ACT_GPU] = |vram_we;

    for (genvar i = 0; i < NUM_ACT_LEDS; i++) begin : g_act
        activity_led u_act (
            .clk       (clk),
            .arst_n    (arst_n),
            .sys_reset (sys_reset),
            .activity  (act[i]),
            .led       (act_led[i])
        );
    end

    assign led_flash = act_led[ACT_FLASH];
    assign led_usb0  = act_led[ACT_USB0];
    assign led_usb1  = act_led[ACT_USB1];
    assign led_eth   = act_led[ACT_ETH];
    assign led_ps2   = act_led[ACT_PS2];
    assign led_gpu   = act_led[ACT_GPU];

    // Level LEDs, all lit while in reset
    assign led_booted = (pc >= BOOTED_PC) | sys_reset;
    assign led_qspi   = ~qspi_mode | sys_reset;

    // Serial port open on the host side
    assign led_serial = stab.dtr_s;

endmodule

// ==== status_pkg.sv ====
/*
 * Status LED constants: hold time, booted threshold and activity slots.
 */
package status_pkg;

    localparam int PC_WIDTH = 27;

    // PC at or past this address means the OS has booted
    localparam logic [PC_WIDTH-1:0] BOOTED_PC = 27'hC02522;

    // Short hold so simulation stays fast, board would use far more
    localparam int LED_HOLD_CYCLES = 32;
    localparam int HOLD_CNT_WIDTH  = 6;

    // Activity LED slots
    localparam int NUM_ACT_LEDS = 6;
    localparam int ACT_FLASH    = 0;
    localparam int ACT_USB0     = 1;
    localparam int ACT_USB1     = 2;
    localparam int ACT_ETH      = 3;
    localparam int ACT_PS2      = 4;
    localparam int ACT_GPU      = 5;

endpackage

// ==== tb_fpgc_board_ctrl.sv ====
/*
 * Table-driven testbench for fpgc_board_ctrl. Each row sets the pins, holds
 * them for some cycles and then checks every output on a falling edge.
 */
`timescale 1ns/1ps

module tb_fpgc_board_ctrl import board_pkg::*, status_pkg::*; ();

    logic                clk;
    logic                arst_n;
    logic                nreset, uart0_dtr, spi1_nint, spi2_nint;
    logic                spi3_int, spi4_gp, frame_drawn, boot_dip;
    logic [PC_WIDTH-1:0] pc;
    logic                qspi_mode;
    logic [3:0]          spi_cs_n;
    logic                ps2_int;
    logic [3:0]          vram_we;
    logic                sys_reset, spi1_rst, spi2_rst, spi3_nrst;
    logic                usb0_nint_stable, usb1_nint_stable, eth_int_stable;
    logic                gp_stable, frame_drawn_stable, boot_mode;
    logic                led_booted, led_qspi, led_serial, led_flash, led_usb0;
    logic                led_usb1, led_eth, led_ps2, led_gpu;

    // Stimulus rows {pins, cs_n, ps2, vram_we, qspi, pc}
    // Expected rows {rst, stable, level, activity}
    logic [44:0] q_stim[$];
    logic [15:0] q_exp[$];
    int          q_hold[$];

    // Edges since each activity slot was last active
    int          act_age[NUM_ACT_LEDS] = '{default: LED_HOLD_CYCLES};
    int          total_cycles = 0;
    int          cycle_limit = 0;
    int          cycle_cnt = 0;
    integer      seed = 40;

    fpgc_board_ctrl UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("Timeout: the stimulus table did not finish in %0d cycles", cycle_limit);
                $display("Checks failed");
                $fatal(1);
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic [7:0] pins, input logic [3:0] cs, input logic ps2,
                           input logic [3:0] vram, input logic qspi,
                           input logic [PC_WIDTH-1:0] pc_val, input int hold,
                           input logic rst, input logic [5:0] stab, input logic [2:0] lvl);
        logic [NUM_ACT_LEDS-1:0] act;
        logic [NUM_ACT_LEDS-1:0] lit;
        act = {|vram, ps2, ~cs[3], ~cs[2], ~cs[1], ~cs[0]};
        // LED stays lit for LED_HOLD_CYCLES edges after the last active edge
        for (int k = 0; k < NUM_ACT_LEDS; k++) begin
            if (act[k]) begin
                act_age[k] = 0;
            end else begin
                act_age[k] += hold;
            end
            lit[k] = (act_age[k] < LED_HOLD_CYCLES);
        end
        q_stim.push_back({pins, cs, ps2, vram, qspi, pc_val});
        q_exp.push_back({rst, stab, lvl, lit});
        q_hold.push_back(hold);
        total_cycles += hold;
    endtask

    // Board pins only with the bus side idle
    task automatic pin_row(input logic [7:0] pins, input int hold, input logic rst,
                           input logic [5:0] stab, input logic [2:0] lvl);
        add_row(pins, 4'hF, 1'b0, 4'h0, 1'b1, '0, hold, rst, stab, lvl);
    endtask

    // Activity only with the board out of reset
    task automatic act_row(input logic [3:0] cs, input logic ps2, input logic [3:0] vram,
                           input int hold);
        add_row(8'h0D, cs, ps2, vram, 1'b1, '0, hold, 1'b0, 6'b000011, 3'b000);
    endtask

    task automatic build_table();
        logic [31:0] r;
        // Pins are {boot, frame, gp, eth, usb1_n, usb0_n, dtr, nreset}
        // Button held then released
        pin_row(8'h0C, 4, 1'b1, 6'b000011, 3'b110);
        pin_row(8'h0D, 2, 1'b1, 6'b000011, 3'b110);
        pin_row(8'h0D, 1, 1'b0, 6'b000011, 3'b000);
        // All six monitored pins flip
        pin_row(8'hF1, SYNC_STAGES - 1, 1'b0, 6'b000011, 3'b000);
        pin_row(8'hF1, 1, 1'b0, 6'b111100, 3'b000);
        // Two more patterns give every pin its own history
        pin_row(8'h39, SYNC_STAGES, 1'b0, 6'b001110, 3'b000);
        pin_row(8'h55, SYNC_STAGES - 1, 1'b0, 6'b001110, 3'b000);
        pin_row(8'h55, 1, 1'b0, 6'b010101, 3'b000);
        pin_row(8'h0D, SYNC_STAGES - 1, 1'b0, 6'b010101, 3'b000);
        pin_row(8'h0D, 1, 1'b0, 6'b000011, 3'b000);
        // Serial port opened
        pin_row(8'h0F, 2, 1'b0, 6'b000011, 3'b001);
        pin_row(8'h0F, 1, 1'b0, 6'b000011, 3'b001);
        pin_row(8'h0F, 1, 1'b1, 6'b000011, 3'b111);
        pin_row(8'h0F, DTR_PULSE_CYCLES - 1, 1'b1, 6'b000011, 3'b111);
        pin_row(8'h0F, 1, 1'b0, 6'b000011, 3'b001);
        pin_row(8'h0D, 1, 1'b0, 6'b000011, 3'b001);
        pin_row(8'h0D, 1, 1'b0, 6'b000011, 3'b000);
        // Flash select retriggered inside the hold
        act_row(4'b1110, 1'b0, 4'h0, 1);
        act_row(4'hF, 1'b0, 4'h0, 20);
        act_row(4'b1110, 1'b0, 4'h0, 1);
        act_row(4'hF, 1'b0, 4'h0, LED_HOLD_CYCLES - 1);
        act_row(4'hF, 1'b0, 4'h0, 1);
        act_row(4'b0101, 1'b1, 4'b0100, 1);
        act_row(4'hF, 1'b0, 4'h0, LED_HOLD_CYCLES - 1);
        act_row(4'hF, 1'b0, 4'h0, 1);
        // Sparse random traffic
        for (int n = 0; n < 80; n++) begin
            r = $random(seed);
            act_row({r[15:12] != 4'd0, r[11:8] != 4'd0, r[7:4] != 4'd0, r[3:0] != 4'd0},
                    r[19:16] == 4'd0,
                    (r[23:20] == 4'd0) ? (4'b0001 << r[25:24]) : 4'b0000, 1);
        end
        act_row(4'hF, 1'b0, 4'h0, LED_HOLD_CYCLES);
        // Booted threshold and QSPI flag
        add_row(8'h0D, 4'hF, 1'b0, 4'h0, 1'b1, BOOTED_PC - 27'd1, 1,
                1'b0, 6'b000011, 3'b000);
        add_row(8'h0D, 4'hF, 1'b0, 4'h0, 1'b1, BOOTED_PC, 1, 1'b0, 6'b000011, 3'b100);
        add_row(8'h0D, 4'hF, 1'b0, 4'h0, 1'b1, 27'h7FFFFFF, 1, 1'b0, 6'b000011, 3'b100);
        add_row(8'h0D, 4'hF, 1'b0, 4'h0, 1'b0, '0, 1, 1'b0, 6'b000011, 3'b010);
        add_row(8'h0C, 4'hF, 1'b0, 4'h0, 1'b1, BOOTED_PC - 27'd1, 3,
                1'b1, 6'b000011, 3'b110);
    endtask

    task automatic check_outputs(input int row, input logic [15:0] exp);
        check_value($sformatf("row %0d sys_reset", row), 32'(sys_reset), 32'(exp[15]));
        check_value($sformatf("row %0d spi1_rst", row), 32'(spi1_rst), 32'(exp[15]));
        check_value($sformatf("row %0d spi2_rst", row), 32'(spi2_rst), 32'(exp[15]));
        check_value($sformatf("row %0d spi3_nrst", row), 32'(spi3_nrst), 32'(!exp[15]));
        check_value($sformatf("row %0d stable inputs", row),
                    32'({boot_mode, frame_drawn_stable, gp_stable, eth_int_stable,
                         usb1_nint_stable, usb0_nint_stable}), 32'(exp[14:9]));
        check_value($sformatf("row %0d level LEDs", row),
                    32'({led_booted, led_qspi, led_serial}), 32'(exp[8:6]));
        check_value($sformatf("row %0d activity LEDs", row),
                    32'({led_gpu, led_ps2, led_eth, led_usb1, led_usb0, led_flash}),
                    32'(exp[5:0]));
    endtask

    initial begin
        arst_n = 1'b0;
        {boot_dip, frame_drawn, spi4_gp, spi3_int, spi2_nint, spi1_nint} = 6'b000011;
        uart0_dtr = 1'b0;
        nreset    = 1'b0;
        pc        = '0;
        qspi_mode = 1'b1;
        spi_cs_n  = 4'hF;
        ps2_int   = 1'b0;
        vram_we   = 4'h0;
        build_table();
        cycle_limit = 10 + total_cycles + 50;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < q_stim.size(); i++) begin
            {boot_dip, frame_drawn, spi4_gp, spi3_int, spi2_nint, spi1_nint, uart0_dtr,
             nreset, spi_cs_n, ps2_int, vram_we, qspi_mode, pc} = q_stim[i];
            repeat (q_hold[i]) @(posedge clk);
            @(negedge clk);
            check_outputs(i, q_exp[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule
